// File: common/led_matrix_cfg.svh
`ifndef LED_MATRIX_CFG_SVH
`define LED_MATRIX_CFG_SVH

// Panel geometry for a 32x16 panel with 1:8 scan.
`define LM_COLS 32
`define LM_SCAN_ROWS 8

// Blanking reload value.
// Each blank phase lasts this value plus one cycles.
`define LM_BLANK_CYCLES 8'd32

// Host port is 16-bit words over 1K words.
`define LM_HOST_AW 10
`define LM_HOST_DW 16

// Pixel address is {half, row[2:0], col[4:0]}.
`define LM_PIX_AW 9

// Low bits select the row, high bits give the PWM level.
`define LM_PHASE_W 11

`endif

// File: common/led_matrix_pkg.sv
package led_matrix_pkg;

  // Scan sequencer states.
  typedef enum logic [2:0] {
    S_IDLE       = 3'b000,
    S_READ_UPPER = 3'b001,
    S_READ_LOWER = 3'b010,
    S_CLOCK      = 3'b011,
    S_LATCH      = 3'b100,
    S_BLANK_PRE  = 3'b101,
    S_BLANK_POST = 3'b111
  } scan_state_e;

  // One pixel as read from the frame buffer.
  // Host word 2p gives green and blue, word 2p+1 gives red in its low byte.
  typedef struct packed {
    logic [7:0] unused;
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } pixel_t;

endpackage

// File: common/host_bus_if.sv
`include "led_matrix_cfg.svh"

interface host_bus_if;

  logic [`LM_HOST_AW-1:0] address;
  logic [`LM_HOST_DW-1:0] wdata;
  logic                   write;
  logic [`LM_HOST_DW-1:0] rdata;

  // Host side drives the request.
  modport bus (
    output address,
    output wdata,
    output write,
    input  rdata
  );

  // Memory side answers one cycle later.
  modport mem (
    input  address,
    input  wdata,
    input  write,
    output rdata
  );

endinterface

// File: hdl/frame_buffer.sv
`include "led_matrix_cfg.svh"

module frame_buffer (
  input  logic                   clk,
  host_bus_if.mem                host,
  input  logic [`LM_PIX_AW-1:0]  pix_addr,
  output led_matrix_pkg::pixel_t pix_data
);

  localparam int BANK_DEPTH = 1 << `LM_PIX_AW;

  logic [`LM_PIX_AW-1:0] host_idx;
  logic                  host_odd_q;

  // Word address bit 0 picks the bank, so one pixel sits at the same index in both.
  assign host_idx = host.address[`LM_HOST_AW-1:1];

  for (genvar b = 0; b < 2; b++) begin : g_bank
    logic [`LM_HOST_DW-1:0] mem [BANK_DEPTH];
    logic [`LM_HOST_DW-1:0] host_q;
    logic [`LM_HOST_DW-1:0] pix_q;

    always_ff @(posedge clk) begin
      if (host.write && (host.address[0] == 1'(b))) begin
        mem[host_idx] <= host.wdata;
      end
      host_q <= mem[host_idx];
    end

    // Scan side never writes.
    always_ff @(posedge clk) begin
      pix_q <= mem[pix_addr];
    end
  end

  always_ff @(posedge clk) begin
    host_odd_q <= host.address[0];
  end

  assign host.rdata = host_odd_q ? g_bank[1].host_q : g_bank[0].host_q;

  // Odd word holds the unused and red bytes.
  assign pix_data = led_matrix_pkg::pixel_t'({g_bank[1].pix_q, g_bank[0].pix_q});

  // Host address and write must be known at every edge.
  a_host_known: assert property (
    @(posedge clk) !$isunknown({host.write, host.address})
  ) else $error("frame_buffer: host write or address unknown");

endmodule

// File: scan/scan_controller.sv
`include "led_matrix_cfg.svh"

module scan_controller (
  input  logic                   clk,
  input  logic                   rst_n,
  output logic [`LM_PIX_AW-1:0]  pix_addr,
  input  led_matrix_pkg::pixel_t pix_data,
  output logic                   row_a,
  output logic                   row_b,
  output logic                   row_c,
  output logic [2:0]             rgb0,
  output logic [2:0]             rgb1,
  output logic                   rgb_clk,
  output logic                   rgb_stb,
  output logic                   oe_n
);

  localparam int COL_W = $clog2(`LM_COLS);
  localparam int ROW_W = $clog2(`LM_SCAN_ROWS);
  localparam int LVL_W = `LM_PHASE_W - ROW_W;
  localparam logic [COL_W-1:0] LAST_COL = COL_W'(`LM_COLS - 1);

  led_matrix_pkg::scan_state_e state;
  led_matrix_pkg::scan_state_e state_next;

  logic [COL_W-1:0]       col;
  logic [COL_W-1:0]       col_next;
  logic [`LM_PHASE_W-1:0] phase;
  logic [`LM_PHASE_W-1:0] phase_next;
  logic [7:0]             delay;
  logic [7:0]             delay_next;
  logic [2:0]             rgb0_next;
  logic [2:0]             rgb1_next;
  logic [ROW_W-1:0]       row;
  logic [ROW_W-1:0]       row_sel;
  logic [LVL_W-1:0]       level;
  logic [2:0]             pix_bits;

  assign row   = phase[ROW_W-1:0];
  assign level = phase[`LM_PHASE_W-1:ROW_W];

  // Upper half is addressed in S_IDLE, lower half in S_READ_UPPER.
  assign pix_addr = {state == led_matrix_pkg::S_READ_UPPER, row, col};

  // Plain PWM, a channel is lit while the level is below its value.
  assign pix_bits = {level < pix_data.red,
                     level < pix_data.green,
                     level < pix_data.blue};

  // The panel shows the row latched last, one behind the phase.
  assign row_sel = row - ROW_W'(1);
  assign row_a   = row_sel[0];
  assign row_b   = row_sel[1];
  assign row_c   = row_sel[2];

  assign rgb_clk = (state == led_matrix_pkg::S_CLOCK);
  assign rgb_stb = (state == led_matrix_pkg::S_LATCH);
  assign oe_n    = (state == led_matrix_pkg::S_BLANK_PRE) ||
                   (state == led_matrix_pkg::S_LATCH) ||
                   (state == led_matrix_pkg::S_BLANK_POST);

  always_comb begin
    state_next = state;
    col_next   = col;
    phase_next = phase;
    delay_next = delay;
    rgb0_next  = rgb0;
    rgb1_next  = rgb1;

    case (state)
      led_matrix_pkg::S_IDLE: begin
        state_next = led_matrix_pkg::S_READ_UPPER;
      end
      led_matrix_pkg::S_READ_UPPER: begin
        rgb0_next  = pix_bits;
        state_next = led_matrix_pkg::S_READ_LOWER;
      end
      led_matrix_pkg::S_READ_LOWER: begin
        rgb1_next  = pix_bits;
        state_next = led_matrix_pkg::S_CLOCK;
      end
      led_matrix_pkg::S_CLOCK: begin
        if (col == LAST_COL) begin
          col_next   = '0;
          delay_next = `LM_BLANK_CYCLES;
          state_next = led_matrix_pkg::S_BLANK_PRE;
        end else begin
          col_next   = col + COL_W'(1);
          state_next = led_matrix_pkg::S_IDLE;
        end
      end
      led_matrix_pkg::S_BLANK_PRE: begin
        if (delay == '0) begin
          state_next = led_matrix_pkg::S_LATCH;
        end else begin
          delay_next = delay - 8'd1;
        end
      end
      led_matrix_pkg::S_LATCH: begin
        // Next row, and a new PWM level once all rows are done.
        phase_next = phase + `LM_PHASE_W'(1);
        delay_next = `LM_BLANK_CYCLES;
        state_next = led_matrix_pkg::S_BLANK_POST;
      end
      led_matrix_pkg::S_BLANK_POST: begin
        if (delay == '0) begin
          state_next = led_matrix_pkg::S_IDLE;
        end else begin
          delay_next = delay - 8'd1;
        end
      end
      default: begin
        state_next = led_matrix_pkg::S_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= led_matrix_pkg::S_IDLE;
      col   <= '0;
      phase <= '0;
      delay <= '0;
      rgb0  <= '0;
      rgb1  <= '0;
    end else begin
      state <= state_next;
      col   <= col_next;
      phase <= phase_next;
      delay <= delay_next;
      rgb0  <= rgb0_next;
      rgb1  <= rgb1_next;
    end
  end

  // Latching a row with the LEDs on would show a smeared line.
  // The row select moves in the cycle after the strobe, so that cycle stays dark too.
  a_stb_blanked: assert property (
    @(posedge clk) disable iff (!rst_n) (rgb_stb || $past(rgb_stb)) |-> oe_n
  ) else $error("scan_controller: oe_n low at or right after rgb_stb");

  // Shift clock has settled before the row is latched.
  a_clk_stb_excl: assert property (
    @(posedge clk) disable iff (!rst_n) rgb_stb |-> !rgb_clk && !$past(rgb_clk)
  ) else $error("scan_controller: rgb_clk at or right before rgb_stb");

  // Row select moves only right after a latch, inside the blanking window.
  a_row_after_stb: assert property (
    @(posedge clk) disable iff (!rst_n) !$stable(row_sel) |-> $past(rgb_stb)
  ) else $error("scan_controller: row select changed outside latch");

endmodule

// File: hdl/led_matrix_top.sv
`include "led_matrix_cfg.svh"

module led_matrix_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`LM_HOST_AW-1:0] address,
  input  logic [`LM_HOST_DW-1:0] data_in,
  input  logic                   write,
  output logic [`LM_HOST_DW-1:0] data_out,
  output logic                   rgb_a,
  output logic                   rgb_b,
  output logic                   rgb_c,
  output logic [2:0]             rgb0,
  output logic [2:0]             rgb1,
  output logic                   rgb_stb,
  output logic                   rgb_clk,
  output logic                   oe_n
);

  logic [`LM_PIX_AW-1:0]  pix_addr;
  led_matrix_pkg::pixel_t pix_data;

  host_bus_if host_bus ();

  assign host_bus.address = address;
  assign host_bus.wdata   = data_in;
  assign host_bus.write   = write;
  assign data_out         = host_bus.rdata;

  frame_buffer fb0 (
    .clk      (clk),
    .host     (host_bus.mem),
    .pix_addr (pix_addr),
    .pix_data (pix_data)
  );

  scan_controller scan0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .pix_addr (pix_addr),
    .pix_data (pix_data),
    .row_a    (rgb_a),
    .row_b    (rgb_b),
    .row_c    (rgb_c),
    .rgb0     (rgb0),
    .rgb1     (rgb1),
    .rgb_clk  (rgb_clk),
    .rgb_stb  (rgb_stb),
    .oe_n     (oe_n)
  );

endmodule

// File: tb/panel_model.sv
`include "led_matrix_cfg.svh"

module panel_model (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`LM_HOST_AW-1:0] address,
  input  logic [`LM_HOST_DW-1:0] data_in,
  input  logic                   write,
  input  logic                   row_a,
  input  logic                   row_b,
  input  logic                   row_c,
  input  logic [2:0]             rgb0,
  input  logic [2:0]             rgb1,
  input  logic                   rgb_clk,
  input  logic                   rgb_stb,
  input  logic                   armed,
  output int                     checked_lines,
  output logic                   fail
);

  localparam int SR_W = 3 * `LM_COLS;

  logic [`LM_HOST_DW-1:0] image [1 << `LM_HOST_AW];
  logic [SR_W-1:0]        upper_sr;
  logic [SR_W-1:0]        lower_sr;
  logic                   active_q    = 1'b0;
  logic                   armed_q     = 1'b0;
  logic [`LM_PHASE_W-1:0] line_count  = '0;
  logic                   compare_row = 1'b0;
  logic                   row_pending = 1'b0;
  logic [2:0]             latched_row = '0;
  logic                   fail_flag   = 1'b0;
  int                     clk_pulses  = 0;
  int                     checked_count = 0;

  assign checked_lines = checked_count;
  assign fail          = fail_flag;

  // Control inputs change on falling edges, so take them on the rising edge.
  always @(posedge clk) begin
    active_q <= rst_n;
    armed_q  <= armed;
    if (write) begin
      image[address] <= data_in;
    end
  end

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    if (!fail_flag) begin
      assert (got == exp) else begin
        $display("Fail at %0t: %s got %0h expected %0h", $time, name, got, exp);
        fail_flag = 1'b1;
      end
    end
  endtask

  // Lit while the level is below the channel value, in red, green, blue order.
  function automatic logic [2:0] expected_bits(input logic half, input logic [2:0] row,
                                               input logic [4:0] col, input logic [7:0] level);
    logic [8:0] pix;
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
    pix   = {half, row, col};
    red   = image[{pix, 1'b1}][7:0];
    green = image[{pix, 1'b0}][15:8];
    blue  = image[{pix, 1'b0}][7:0];
    return {level < red, level < green, level < blue};
  endfunction

  // Column 0 was shifted first, so it sits at the far end.
  task automatic check_line;
    logic [7:0] level;
    logic [2:0] row;
    level = line_count[10:3];
    row   = line_count[2:0];
    for (int c = 0; c < `LM_COLS; c++) begin
      check_value($sformatf("rgb0 row %0d column %0d", row, c),
                  16'(upper_sr[3*(`LM_COLS-1-c) +: 3]),
                  16'(expected_bits(1'b0, row, 5'(c), level)));
      check_value($sformatf("rgb1 row %0d column %0d", row, c),
                  16'(lower_sr[3*(`LM_COLS-1-c) +: 3]),
                  16'(expected_bits(1'b1, row, 5'(c), level)));
    end
  endtask

  always @(negedge clk) begin
    if (!active_q) begin
      line_count  = '0;
      compare_row = 1'b0;
      row_pending = 1'b0;
      clk_pulses  = 0;
    end else begin
      if (row_pending) begin
        check_value("row select", 16'({row_c, row_b, row_a}), 16'(latched_row));
        row_pending = 1'b0;
      end
      if (rgb_clk) begin
        upper_sr = {upper_sr[SR_W-4:0], rgb0};
        lower_sr = {lower_sr[SR_W-4:0], rgb1};
        clk_pulses++;
      end
      if (rgb_stb) begin
        check_value("rgb_clk pulses per line", 16'(clk_pulses), 16'(`LM_COLS));
        if (compare_row) begin
          check_line();
          checked_count++;
        end
        latched_row = line_count[2:0];
        row_pending = 1'b1;
        compare_row = armed_q;
        line_count  = line_count + `LM_PHASE_W'(1);
        clk_pulses  = 0;
      end
    end
  end

endmodule

// File: tb/led_matrix_tb.sv
`include "led_matrix_cfg.svh"

module led_matrix_tb;

  localparam int CLK_PERIOD   = 100;
  localparam int WORDS        = 1 << `LM_HOST_AW;
  localparam int MIXED_OPS    = 256;
  localparam int CHECK_LINES  = 64;
  localparam int BLANK_WINDOW = 2 * int'(`LM_BLANK_CYCLES) + 3;
  localparam int LINE_CYCLES  = 4 * `LM_COLS + BLANK_WINDOW;
  localparam int LOAD_CYCLES  = WORDS + MIXED_OPS + 8;
  localparam int LIMIT_CYCLES = LOAD_CYCLES + 70 * LINE_CYCLES + 200;

  logic                   clk;
  logic                   rst_n;
  logic [`LM_HOST_AW-1:0] address;
  logic [`LM_HOST_DW-1:0] data_in;
  logic                   write;
  logic [`LM_HOST_DW-1:0] data_out;
  logic                   rgb_a;
  logic                   rgb_b;
  logic                   rgb_c;
  logic [2:0]             rgb0;
  logic [2:0]             rgb1;
  logic                   rgb_stb;
  logic                   rgb_clk;
  logic                   oe_n;
  logic                   armed;
  int                     checked_lines;
  logic                   model_fail;
  int                     blank_run = 0;

  // Host-side copy of every word written.
  logic [`LM_HOST_DW-1:0] shadow [WORDS];

  always #(CLK_PERIOD / 2) clk = ~clk;

  led_matrix_top dut0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .address  (address),
    .data_in  (data_in),
    .write    (write),
    .data_out (data_out),
    .rgb_a    (rgb_a),
    .rgb_b    (rgb_b),
    .rgb_c    (rgb_c),
    .rgb0     (rgb0),
    .rgb1     (rgb1),
    .rgb_stb  (rgb_stb),
    .rgb_clk  (rgb_clk),
    .oe_n     (oe_n)
  );

  panel_model model0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .address       (address),
    .data_in       (data_in),
    .write         (write),
    .row_a         (rgb_a),
    .row_b         (rgb_b),
    .row_c         (rgb_c),
    .rgb0          (rgb0),
    .rgb1          (rgb1),
    .rgb_clk       (rgb_clk),
    .rgb_stb       (rgb_stb),
    .armed         (armed),
    .checked_lines (checked_lines),
    .fail          (model_fail)
  );

  task automatic stop_with_failure;
    $display("test failed");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic expect_equal(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
    assert (got == exp) else begin
      $display("Fail at %0t: %s got %0h expected %0h", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic write_word(input logic [`LM_HOST_AW-1:0] addr,
                            input logic [`LM_HOST_DW-1:0] data);
    address     = addr;
    data_in     = data;
    write       = 1'b1;
    shadow[addr] = data;
  endtask

  // Reset values, checked before the first rising edge after release.
  task automatic check_reset_outputs;
    expect_equal("rgb_stb", 16'(rgb_stb), 16'h0);
    expect_equal("rgb_clk", 16'(rgb_clk), 16'h0);
    expect_equal("oe_n", 16'(oe_n), 16'h0);
    expect_equal("rgb0", 16'(rgb0), 16'h0);
    expect_equal("rgb1", 16'(rgb1), 16'h0);
    expect_equal("row select", 16'({rgb_c, rgb_b, rgb_a}), 16'd7);
  endtask

  // Blanking window length and strobe only while blanked.
  always @(negedge clk) begin
    if (rgb_stb) begin
      expect_equal("oe_n during rgb_stb", 16'(oe_n), 16'h1);
    end
    if (oe_n) begin
      blank_run++;
    end else begin
      if (blank_run != 0) begin
        expect_equal("oe_n high cycles", 16'(blank_run), 16'(BLANK_WINDOW));
      end
      blank_run = 0;
    end
  end

  always @(posedge model_fail) begin
    stop_with_failure();
  end

  initial begin
    #(LIMIT_CYCLES * CLK_PERIOD);
    $display("Timeout: the panel checks did not finish within %0d cycles", LIMIT_CYCLES);
    stop_with_failure();
  end

  initial begin
    logic                   pend_read;
    logic [`LM_HOST_AW-1:0] pend_addr;
    logic [`LM_HOST_AW-1:0] addr;
    clk       = 1'b0;
    rst_n     = 1'b0;
    address   = '0;
    data_in   = '0;
    write     = 1'b0;
    armed     = 1'b0;
    pend_read = 1'b0;
    pend_addr = '0;
    void'($urandom(32'h977));

    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    check_reset_outputs();

    // Whole image, written while the scan already runs.
    for (int i = 0; i < WORDS; i++) begin
      @(negedge clk);
      write_word(`LM_HOST_AW'(i), 16'($urandom));
    end

    // Random reads with some writes mixed in.
    for (int i = 0; i < MIXED_OPS; i++) begin
      @(negedge clk);
      if (pend_read) begin
        expect_equal("data_out", data_out, shadow[pend_addr]);
      end
      addr = `LM_HOST_AW'($urandom);
      if ($urandom_range(3) == 0) begin
        write_word(addr, 16'($urandom));
        pend_read = 1'b0;
      end else begin
        address   = addr;
        write     = 1'b0;
        pend_read = 1'b1;
        pend_addr = addr;
      end
    end
    @(negedge clk);
    if (pend_read) begin
      expect_equal("data_out", data_out, shadow[pend_addr]);
    end
    write = 1'b0;
    armed = 1'b1;

    while (checked_lines < CHECK_LINES) begin
      @(negedge clk);
    end

    if (model_fail) begin
      stop_with_failure();
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

// File: build.f
+incdir+common
common/led_matrix_pkg.sv
common/host_bus_if.sv
hdl/frame_buffer.sv
scan/scan_controller.sv
hdl/led_matrix_top.sv
tb/panel_model.sv
tb/led_matrix_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the LED matrix testbench with Verilator.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f build.f \
    --top-module led_matrix_tb -o led_matrix_sim; then
  echo "Verilator build failed"
  exit 1
fi

sim_output=$(./obj_dir/led_matrix_sim 2>&1)
sim_status=$?
printf '%s\n' "$sim_output"

if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_output" | grep -qx "test passed"; then
  exit 0
else
  echo "Pass message not found in simulation output"
  exit 1
fi
